// ==== verification/pipeControlInput.txt ====
# cmd rs rt rd wr ld bt lk mul mt mf rsValue rtValue, then expected fwdAD fwdBD fwdAE fwdBE
# stallPc stallIfId flushIfId flushIdEx mulBusy hiLoValue; all hex, cmd 1 waits for mulBusy low
0 00 00 03 1 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 00 00 03 1 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 00 00 00 1 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 03 00 00 0 0 0 0 0 0 0 00000000 00000000 1 0 0 0 0 0 0 0 0 00000000
0 00 03 00 0 0 0 0 0 0 0 00000000 00000000 0 2 2 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 00 00 07 1 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 07 07 00 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 07 00 00 0 0 0 0 0 0 0 00000000 00000000 1 0 1 1 0 0 0 0 0 00000000
0 00 07 00 0 0 0 0 0 0 0 00000000 00000000 0 2 2 0 0 0 0 0 0 00000000
0 00 00 05 1 1 0 0 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 05 00 00 0 0 0 0 0 0 0 00000000 00000000 0 0 0 0 1 1 0 1 0 00000000
0 05 00 00 0 0 0 0 0 0 0 00000000 00000000 1 0 0 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 0 0 0 0 00000000 00000000 0 0 2 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 1 0 0 0 00000000 00000000 0 0 0 0 0 0 1 0 0 00000000
0 00 00 00 0 0 1 1 0 0 0 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 0 0 2 0 13579bdf 00000000 0 0 0 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 0 0 1 2 2468ace0 00000000 0 0 0 0 0 0 0 0 0 13579bdf
0 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 0 0 0 0 0 2468ace0
0 00 00 00 0 0 0 0 1 0 0 fffffffd 00000007 0 0 0 0 0 0 0 0 0 00000000
0 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 1 1 0 1 1 2468ace0
0 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 1 1 0 1 1 2468ace0
1 00 00 00 0 0 0 0 0 0 2 00000000 00000000 0 0 0 0 0 0 0 0 0 ffffffeb
0 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 0 0 0 0 0 ffffffff
0 00 00 00 0 0 0 0 2 0 0 fffffffd 00000007 0 0 0 0 0 0 0 0 0 00000000
1 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 0 0 0 0 0 00000006
0 00 00 00 0 0 0 0 0 0 2 00000000 00000000 0 0 0 0 0 0 0 0 0 ffffffeb
0 00 00 00 0 0 0 0 1 0 0 80000000 ffffffff 0 0 0 0 0 0 0 0 0 00000000
1 00 00 00 0 0 0 0 0 0 2 00000000 00000000 0 0 0 0 0 0 0 0 0 80000000
0 00 00 00 0 0 0 0 0 0 1 00000000 00000000 0 0 0 0 0 0 0 0 0 00000000

// ==== sources.f ====
source/hazardPkg.sv
source/hazardControl.sv
source/stageTracker.sv
source/mulDivSequencer.sv
source/mulCycleTimer.sv
source/hiLoUnit.sv
source/pipeControlTop.sv
verification/pipeControlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= pipeControlTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== verification/pipeControlTb.sv ====
`timescale 1ns/1ps

module pipeControlTb import hazardPkg::*; ();

    logic     clk;
    logic     reset;
    regAddrT  rsD;
    regAddrT  rtD;
    regAddrT  regAddrD;
    logic     regWriteD;
    logic     memToRegD;
    logic     branchTakenD;
    logic     likelyD;
    mulOpT    mulOpD;
    hiLoMoveT moveToD;
    hiLoMoveT moveFromD;
    wordT     rsValueD;
    wordT     rtValueD;
    fwdSelT   forwardAD;
    fwdSelT   forwardBD;
    fwdSelT   forwardAE;
    fwdSelT   forwardBE;
    logic     stallPc;
    logic     stallIfId;
    logic     flushIfId;
    logic     flushIdEx;
    logic     mulBusy;
    wordT     hiLoValue;

    wordT col [23]; // fields of the current stimulus line
    int   lineNo;
    int   busyCycles;
    int   checkedLines;

    pipeControlTop i_pipeControlTop (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic expectValue(input string what, input wordT got, input wordT exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s is %h, expected %h (input line %0d)",
                     $time, what, got, exp, lineNo);
            $display("TB FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic applyInputs();
        rsD          = col[1][4:0];
        rtD          = col[2][4:0];
        regAddrD     = col[3][4:0];
        regWriteD    = col[4][0];
        memToRegD    = col[5][0];
        branchTakenD = col[6][0];
        likelyD      = col[7][0];
        mulOpD       = mulOpT'(col[8][1:0]);
        moveToD      = hiLoMoveT'(col[9][1:0]);
        moveFromD    = hiLoMoveT'(col[10][1:0]);
        rsValueD     = col[11];
        rtValueD     = col[12];
    endtask

    task automatic checkOutputs();
        expectValue("forwardAD", wordT'(forwardAD), col[13]);
        expectValue("forwardBD", wordT'(forwardBD), col[14]);
        expectValue("forwardAE", wordT'(forwardAE), col[15]);
        expectValue("forwardBE", wordT'(forwardBE), col[16]);
        expectValue("stallPc", wordT'(stallPc), col[17]);
        expectValue("stallIfId", wordT'(stallIfId), col[18]);
        expectValue("flushIfId", wordT'(flushIfId), col[19]);
        expectValue("flushIdEx", wordT'(flushIdEx), col[20]);
        expectValue("mulBusy", wordT'(mulBusy), col[21]);
        expectValue("hiLoValue", hiLoValue, col[22]);
    endtask

    task automatic countBusy();
        if (mulBusy) begin
            busyCycles++;
        end
    endtask

    // decode inputs stay as driven while the multiply runs
    task automatic waitMulDone();
        int guard;
        guard = 0;
        while (mulBusy) begin
            if (guard >= MulCycles + 5) begin
                $display("multiply still busy after %0d cycles (input line %0d)", guard, lineNo);
                $display("TB FAILED");
                $fatal(1, "multiply timeout");
            end
            @(negedge clk);
            #3;
            countBusy();
            guard++;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        string lineText;
        reset        = 1'b1;
        rsD          = '0;
        rtD          = '0;
        regAddrD     = '0;
        regWriteD    = 1'b0;
        memToRegD    = 1'b0;
        branchTakenD = 1'b0;
        likelyD      = 1'b0;
        mulOpD       = mulNone;
        moveToD      = moveNone;
        moveFromD    = moveNone;
        rsValueD     = '0;
        rtValueD     = '0;
        lineNo       = 0;
        busyCycles   = 0;
        checkedLines = 0;
        fd = $fopen("verification/pipeControlInput.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/pipeControlInput.txt");
            $display("TB FAILED");
            $fatal(1, "no stimulus file");
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while ($fgets(lineText, fd) != 0) begin
            lineNo++;
            if (lineText.len() < 2 || lineText[0] == "#") begin
                continue;
            end
            code = $sscanf(lineText,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                col[16], col[17], col[18], col[19], col[20], col[21], col[22]);
            if (code != 23) begin
                $display("input line %0d holds %0d fields instead of 23", lineNo, code);
                $display("TB FAILED");
                $fatal(1, "bad stimulus line");
            end
            applyInputs();
            #3; // 1 ns ahead of the rising edge
            countBusy();
            if (col[0] == 32'd1) begin
                waitMulDone();
            end
            checkOutputs();
            if (col[0] == 32'd1) begin
                expectValue("mulBusy cycle count", busyCycles, MulCycles + 1);
                busyCycles = 0;
            end
            checkedLines++;
            @(negedge clk);
        end
        $fclose(fd);
        if (checkedLines > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("the stimulus file holds no data lines");
            $display("TB FAILED");
            $fatal(1, "empty stimulus");
        end
    end

endmodule

// ==== source/pipeControlTop.sv ====
`timescale 1ns/1ps

module pipeControlTop import hazardPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddrT  rsD,
    input  regAddrT  rtD,
    input  regAddrT  regAddrD,
    input  logic     regWriteD,
    input  logic     memToRegD,
    input  logic     branchTakenD,
    input  logic     likelyD,
    input  mulOpT    mulOpD,
    input  hiLoMoveT moveToD,
    input  hiLoMoveT moveFromD,
    input  wordT     rsValueD,
    input  wordT     rtValueD,
    output fwdSelT   forwardAD,
    output fwdSelT   forwardBD,
    output fwdSelT   forwardAE,
    output fwdSelT   forwardBE,
    output logic     stallPc,
    output logic     stallIfId,
    output logic     flushIfId,
    output logic     flushIdEx,
    output logic     mulBusy,
    output wordT     hiLoValue
);

    regAddrT  rsE;
    regAddrT  rtE;
    regAddrT  regAddrE;
    regAddrT  regAddrM;
    regAddrT  regAddrW;
    logic     memToRegE;
    logic     regWriteM;
    logic     regWriteW;
    logic     mulStart;
    logic     mulSignedD;
    hiLoMoveT moveToIssued;
    logic     timerLoad;
    logic     timerDone;
    logic     stepEnable;
    logic     hiLoWrite;

    // only issued ops reach the multiplier
    assign mulStart     = (mulOpD != mulNone) && !stallIfId;
    assign mulSignedD   = (mulOpD == mulSigned);
    assign moveToIssued = stallIfId ? moveNone : moveToD;

    hazardControl i_hazardControl (
        .rsD, .rtD, .rsE, .rtE, .regAddrE, .regAddrM, .regAddrW,
        .regWriteM, .regWriteW, .memToRegE, .branchTakenD, .likelyD, .mulBusy,
        .mulOpD, .moveToD, .moveFromD,
        .forwardAD, .forwardBD, .forwardAE, .forwardBE,
        .stallPc, .stallIfId, .flushIfId, .flushIdEx
    );

    stageTracker i_stageTracker (
        .clk, .reset, .flushIdEx, .rsD, .rtD, .regAddrD, .regWriteD, .memToRegD,
        .rsE, .rtE, .regAddrE, .regAddrM, .regAddrW, .memToRegE, .regWriteM, .regWriteW
    );

    mulDivSequencer i_mulDivSequencer (
        .clk, .reset, .mulStart, .timerDone,
        .timerLoad, .stepEnable, .hiLoWrite, .mulBusy
    );

    mulCycleTimer i_mulCycleTimer (
        .clk, .reset, .timerLoad, .stepEnable, .timerDone
    );

    hiLoUnit i_hiLoUnit (
        .clk, .reset, .mulStart, .mulSignedD, .rsValueD, .rtValueD, .stepEnable, .hiLoWrite,
        .moveToD(moveToIssued), .moveFromD, .hiLoValue
    );

endmodule

// ==== source/hiLoUnit.sv ====
`timescale 1ns/1ps

module hiLoUnit import hazardPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mulStart,
    input  logic     mulSignedD,
    input  wordT     rsValueD,
    input  wordT     rtValueD,
    input  logic     stepEnable,
    input  logic     hiLoWrite,
    input  hiLoMoveT moveToD,
    input  hiLoMoveT moveFromD,
    output wordT     hiLoValue
);

    logic [63:0] acc; // partial product over multiplier bits
    logic [63:0] product;
    logic [32:0] upperSum;
    wordT        mcand;
    wordT        rsMag;
    wordT        rtMag;
    logic        negate;
    wordT        hi;
    wordT        lo;

    always_comb begin
        rsMag    = (mulSignedD && rsValueD[31]) ? -rsValueD : rsValueD;
        rtMag    = (mulSignedD && rtValueD[31]) ? -rtValueD : rtValueD;
        upperSum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
        product  = negate ? -acc : acc;
    end

    always_ff @(posedge clk) begin
        if (mulStart) begin
            acc    <= {32'd0, rtMag};
            mcand  <= rsMag;
            negate <= mulSignedD && (rsValueD[31] ^ rtValueD[31]);
        end else if (stepEnable) begin
            acc <= {upperSum, acc[31:1]}; // add then shift right
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (hiLoWrite) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end else begin
            case (moveToD)
                moveHi:  hi <= rsValueD;
                moveLo:  lo <= rsValueD;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (moveFromD)
            moveHi:  hiLoValue = hi;
            moveLo:  hiLoValue = lo;
            default: hiLoValue = '0;
        endcase
    end

endmodule

// ==== source/mulCycleTimer.sv ====
`timescale 1ns/1ps

module mulCycleTimer import hazardPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic timerLoad,
    input  logic stepEnable,
    output logic timerDone
);

    countT count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (timerLoad) begin
            count <= countT'(MulCycles - 1);
        end else if (stepEnable && count != '0) begin
            count <= count - countT'(1); // holds at zero
        end
    end

    assign timerDone = (count == '0);

endmodule

// ==== source/mulDivSequencer.sv ====
`timescale 1ns/1ps

module mulDivSequencer import hazardPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic mulStart,
    input  logic timerDone,
    output logic timerLoad,
    output logic stepEnable,
    output logic hiLoWrite,
    output logic mulBusy
);

    mulStateT state;
    mulStateT stateNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mulIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            mulIdle: begin
                if (mulStart) begin
                    stateNext = mulRun;
                end
            end
            mulRun: begin
                if (timerDone) begin // last step this cycle
                    stateNext = mulWrite;
                end
            end
            mulWrite: begin
                stateNext = mulIdle;
            end
            default: begin
                stateNext = mulIdle;
            end
        endcase
    end

    assign timerLoad  = (state == mulIdle) && mulStart;
    assign stepEnable = (state == mulRun);
    assign hiLoWrite  = (state == mulWrite);
    assign mulBusy    = (state != mulIdle); // run plus write phase

endmodule

// ==== source/stageTracker.sv ====
`timescale 1ns/1ps

module stageTracker import hazardPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    flushIdEx,
    input  regAddrT rsD,
    input  regAddrT rtD,
    input  regAddrT regAddrD,
    input  logic    regWriteD,
    input  logic    memToRegD,
    output regAddrT rsE,
    output regAddrT rtE,
    output regAddrT regAddrE,
    output regAddrT regAddrM,
    output regAddrT regAddrW,
    output logic    memToRegE,
    output logic    regWriteM,
    output logic    regWriteW
);

    logic regWriteE;

    // ID/EX, a flush loads an empty slot
    always_ff @(posedge clk) begin
        if (reset || flushIdEx) begin
            rsE       <= '0;
            rtE       <= '0;
            regAddrE  <= '0;
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
        end else begin
            rsE       <= rsD;
            rtE       <= rtD;
            regAddrE  <= regAddrD;
            regWriteE <= regWriteD;
            memToRegE <= memToRegD;
        end
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            regAddrM  <= '0;
            regWriteM <= 1'b0;
        end else begin
            regAddrM  <= regAddrE;
            regWriteM <= regWriteE;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            regAddrW  <= '0;
            regWriteW <= 1'b0;
        end else begin
            regAddrW  <= regAddrM;
            regWriteW <= regWriteM;
        end
    end

endmodule

// ==== source/hazardControl.sv ====
`timescale 1ns/1ps

module hazardControl import hazardPkg::*; (
    input  regAddrT  rsD,
    input  regAddrT  rtD,
    input  regAddrT  rsE,
    input  regAddrT  rtE,
    input  regAddrT  regAddrE,
    input  regAddrT  regAddrM,
    input  regAddrT  regAddrW,
    input  logic     regWriteM,
    input  logic     regWriteW,
    input  logic     memToRegE,
    input  logic     branchTakenD,
    input  logic     likelyD,
    input  logic     mulBusy,
    input  mulOpT    mulOpD,
    input  hiLoMoveT moveToD,
    input  hiLoMoveT moveFromD,
    output fwdSelT   forwardAD,
    output fwdSelT   forwardBD,
    output fwdSelT   forwardAE,
    output fwdSelT   forwardBE,
    output logic     stallPc,
    output logic     stallIfId,
    output logic     flushIfId,
    output logic     flushIdEx
);

    logic loadStall;
    logic mulStall;
    logic hiLoOpD;
    logic anyStall;

    // memory stage wins over writeback, r0 never forwarded
    function automatic fwdSelT selectForward(
        input regAddrT src,
        input regAddrT addrM,
        input logic    writeM,
        input regAddrT addrW,
        input logic    writeW
    );
        fwdSelT sel;
        if (src == ZeroReg) begin
            sel = fwdNone;
        end else if (writeM && src == addrM) begin
            sel = fwdMem;
        end else if (writeW && src == addrW) begin
            sel = fwdWb;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    assign forwardAD = selectForward(rsD, regAddrM, regWriteM, regAddrW, regWriteW);
    assign forwardBD = selectForward(rtD, regAddrM, regWriteM, regAddrW, regWriteW);
    assign forwardAE = selectForward(rsE, regAddrM, regWriteM, regAddrW, regWriteW);
    assign forwardBE = selectForward(rtE, regAddrM, regWriteM, regAddrW, regWriteW);

    // load in execute feeding decode, no r0 exemption
    assign loadStall = memToRegE && (rsD == regAddrE || rtD == regAddrE);

    assign hiLoOpD  = (mulOpD != mulNone) || (moveToD != moveNone) || (moveFromD != moveNone);
    assign mulStall = mulBusy && hiLoOpD;
    assign anyStall = loadStall || mulStall;

    assign stallPc   = anyStall;
    assign stallIfId = anyStall;
    assign flushIdEx = anyStall; // bubble into execute
    assign flushIfId = likelyD && !branchTakenD; // squash delay slot

endmodule

// ==== source/hazardPkg.sv ====
package hazardPkg;

    // shift-add iterations per multiply
    localparam int MulCycles = 32;

    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] wordT;
    typedef logic [5:0]  countT;

    // register 0 is hardwired, never a forwarding source
    localparam regAddrT ZeroReg = 5'd0;

    typedef enum logic [1:0] {
        fwdNone = 2'b00, // register file value
        fwdMem  = 2'b01, // memory-stage result
        fwdWb   = 2'b10  // writeback result
    } fwdSelT;

    typedef enum logic [1:0] {
        mulNone     = 2'b00,
        mulSigned   = 2'b01,
        mulUnsigned = 2'b10
    } mulOpT;

    // shared by move-to and move-from
    typedef enum logic [1:0] {
        moveNone = 2'b00,
        moveHi   = 2'b01,
        moveLo   = 2'b10
    } hiLoMoveT;

    typedef enum logic [1:0] {
        mulIdle  = 2'b00,
        mulRun   = 2'b01,
        mulWrite = 2'b10
    } mulStateT;

endpackage
